//--- masku_macros.svh
// Mask unit constants
// Word width, byte strobes, length and id widths, result queue depth
// Shared by the package and the datapath modules

`ifndef MASKU_MACROS_SVH
`define MASKU_MACROS_SVH

// Datapath word and its byte strobes
`define MASKU_DATA_W   64
`define MASKU_STRB_W   8

// Vector length in elements
`define MASKU_VL_W     12

// Instruction id carried back with done
`define MASKU_ID_W     3

// Register file word address
`define MASKU_ADDR_W   8

// Result words buffered toward the register file
`define MASKU_RQ_DEPTH 2

`endif

//--- masku_pkg.sv
// Mask unit package
// Vector typedefs, op and state encodings, request, operand and result structs

`include "masku_macros.svh"

package masku_pkg;

  ////////////////////////////////
  // Plain vector types
  ////////////////////////////////

  typedef logic [`MASKU_DATA_W-1:0] elen_t;
  typedef logic [`MASKU_STRB_W-1:0] strb_t;
  typedef logic [`MASKU_VL_W-1:0]   vlen_t;
  typedef logic [`MASKU_ID_W-1:0]   vid_t;
  typedef logic [`MASKU_ADDR_W-1:0] vaddr_t;
  // Set bits in one word, 0 to 64
  typedef logic [6:0]               cnt_t;

  ////////////////////////////////
  // Encodings
  ////////////////////////////////

  typedef enum logic {
    OP_MASK_LOGIC,
    OP_VCPOP
  } masku_op_e;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN,
    DONE
  } masku_state_e;

  ////////////////////////////////
  // Structs
  ////////////////////////////////

  // Instruction from the sequencer
  typedef struct packed {
    masku_op_e op;
    vlen_t     vl;
    logic      vm;
    vaddr_t    vd;
    vid_t      id;
  } pe_req_t;

  // One operand beat
  // a is the ALU result, b the old destination, m the mask register
  typedef struct packed {
    elen_t a;
    elen_t b;
    elen_t m;
  } operand_t;

  // One register file write
  typedef struct packed {
    vaddr_t addr;
    vid_t   id;
    elen_t  wdata;
    strb_t  be;
  } result_t;

endpackage

//--- masku_ctrl_fsm.sv
// Mask unit controller
// Accepts one instruction at a time, tracks beat processing and
// signals completion back to the sequencer

module masku_ctrl_fsm (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 pe_req_valid_i,
  input  masku_pkg::masku_op_e req_op_i,
  input  logic                 last_beat_i,
  input  logic                 zero_len_i,
  input  logic                 beat_fire_i,
  input  logic                 queue_empty_i,
  output logic                 pe_req_ready_o,
  output logic                 accept_o,
  output masku_pkg::masku_op_e busy_op_o,
  output logic                 done_valid_o
);

  masku_pkg::masku_state_e state_d, state_q;
  masku_pkg::masku_op_e    op_q;
  logic                    ready_q;

  // Handshake with the sequencer
  assign accept_o       = pe_req_valid_i && ready_q;
  assign pe_req_ready_o = ready_q;
  assign busy_op_o      = op_q;

  // Done in DONE, or as soon as the last result word has left in DRAIN
  assign done_valid_o = (state_q == masku_pkg::DONE) ||
                        ((state_q == masku_pkg::DRAIN) && queue_empty_i);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      masku_pkg::IDLE: begin
        if (accept_o) begin
          // Empty instruction completes without beats
          state_d = zero_len_i ? masku_pkg::DONE : masku_pkg::RUN;
        end
      end
      masku_pkg::RUN: begin
        if (beat_fire_i && last_beat_i) begin
          // Scalar result needs no writeback
          state_d = (op_q == masku_pkg::OP_VCPOP) ? masku_pkg::DONE : masku_pkg::DRAIN;
        end
      end
      masku_pkg::DRAIN: begin
        if (queue_empty_i) begin
          state_d = masku_pkg::IDLE;
        end
      end
      masku_pkg::DONE: begin
        state_d = masku_pkg::IDLE;
      end
      default: state_d = masku_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= masku_pkg::IDLE;
      op_q    <= masku_pkg::OP_MASK_LOGIC;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Ready follows IDLE, low for the first cycle out of reset
      ready_q <= (state_d == masku_pkg::IDLE);
      if (accept_o) begin
        op_q <= req_op_i;
      end
    end
  end

endmodule

//--- masku_elem_counter.sv
// Element counter for the active instruction
// Tracks elements still to process and the index of the next beat

`include "masku_macros.svh"

module masku_elem_counter (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              load_i,
  input  masku_pkg::vlen_t  vl_i,
  input  logic              beat_fire_i,
  output masku_pkg::vlen_t  remaining_o,
  output masku_pkg::vaddr_t beat_idx_o,
  output logic              last_beat_o,
  output logic              zero_len_o
);

  // Elements covered by one beat
  localparam masku_pkg::vlen_t BeatElems = masku_pkg::vlen_t'(`MASKU_DATA_W);

  masku_pkg::vlen_t  remaining_q;
  masku_pkg::vaddr_t beat_idx_q;

  assign remaining_o = remaining_q;
  assign beat_idx_o  = beat_idx_q;
  // Final beat holds at most one word of elements
  assign last_beat_o = (remaining_q <= BeatElems);
  // Seen on the incoming request, before the load
  assign zero_len_o  = (vl_i == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remaining_q <= '0;
      beat_idx_q  <= '0;
    end else if (load_i) begin
      remaining_q <= vl_i;
      beat_idx_q  <= '0;
    end else if (beat_fire_i) begin
      // Saturate so an idle unit reads zero remaining
      remaining_q <= (remaining_q > BeatElems) ? remaining_q - BeatElems : '0;
      beat_idx_q  <= beat_idx_q + 1'b1;
    end
  end

endmodule

//--- masku_alu.sv
// Mask ALU
// Builds the bit enable from the remaining count and the mask,
// merges the lane result into the old destination and counts
// the enabled set bits of b

`include "masku_macros.svh"

module masku_alu (
  input  masku_pkg::operand_t operand_i,
  input  masku_pkg::vlen_t    remaining_i,
  input  logic                vm_i,
  output masku_pkg::elen_t    merged_o,
  output masku_pkg::strb_t    be_o,
  output masku_pkg::cnt_t     popcnt_o
);

  localparam int unsigned ShiftW = $clog2(`MASKU_DATA_W);

  masku_pkg::elen_t len_mask;
  masku_pkg::elen_t bit_en;
  masku_pkg::elen_t to_count;

  ////////////////////////////////
  // Bit enable
  ////////////////////////////////

  always_comb begin
    // Full word when at least 64 elements are left
    if (remaining_i >= masku_pkg::vlen_t'(`MASKU_DATA_W)) begin
      len_mask = '1;
    end else begin
      len_mask = (masku_pkg::elen_t'(1) << remaining_i[ShiftW-1:0]) - masku_pkg::elen_t'(1);
    end
  end

  // Mask register only applies when vm is low
  assign bit_en = vm_i ? len_mask : (len_mask & operand_i.m);

  ////////////////////////////////
  // Merge and byte enables
  ////////////////////////////////

  // Bitwise select, a where enabled, old value elsewhere
  assign merged_o = (operand_i.a & bit_en) | (operand_i.b & ~bit_en);

  // A byte is written if it holds any element below vl
  always_comb begin
    for (int i = 0; i < `MASKU_STRB_W; i++) begin
      be_o[i] = |len_mask[8*i +: 8];
    end
  end

  ////////////////////////////////
  // Population count
  ////////////////////////////////

  assign to_count = operand_i.b & bit_en;

  always_comb begin
    popcnt_o = '0;
    for (int i = 0; i < `MASKU_DATA_W; i++) begin
      popcnt_o = popcnt_o + masku_pkg::cnt_t'(to_count[i]);
    end
  end

endmodule

//--- masku_popcnt_acc.sv
// Popcount accumulator for vcpop
// Sums per-beat counts and presents the total as a scalar

module masku_popcnt_acc (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              add_i,
  input  masku_pkg::cnt_t   popcnt_i,
  input  logic              last_i,
  output masku_pkg::elen_t  scalar_o,
  output logic              scalar_valid_o
);

  // Total never exceeds vl, so an element count is wide enough
  masku_pkg::vlen_t sum_q;
  masku_pkg::vlen_t sum_d;
  masku_pkg::vlen_t total_q;
  logic             valid_q;

  // Clear and add in one cycle start a fresh sum
  assign sum_d = (clear_i ? '0 : sum_q) + masku_pkg::vlen_t'(popcnt_i);

  assign scalar_o       = masku_pkg::elen_t'(total_q);
  assign scalar_valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sum_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      // Single-cycle pulse after the final add
      valid_q <= add_i && last_i;
      if (add_i) begin
        sum_q <= sum_d;
      end else if (clear_i) begin
        sum_q <= '0;
      end
    end
  end

  // Result register, loaded once per instruction
  always_ff @(posedge clk_i) begin
    if (add_i && last_i) begin
      total_q <= sum_d;
    end
  end

endmodule

//--- masku_result_queue.sv
// Result queue toward the vector register file
// Small circular buffer, head presented with req until granted

`include "masku_macros.svh"

module masku_result_queue (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               push_i,
  input  masku_pkg::result_t push_data_i,
  input  logic               result_gnt_i,
  output logic               full_o,
  output logic               empty_o,
  output masku_pkg::result_t result_o,
  output logic               result_req_o
);

  localparam int unsigned Depth = `MASKU_RQ_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  masku_pkg::result_t    mem_q [Depth];
  logic [PtrW-1:0]       wr_ptr_q;
  logic [PtrW-1:0]       rd_ptr_q;
  logic [CntW-1:0]       cnt_q;
  logic                  pop;

  assign full_o  = (cnt_q == CntW'(Depth));
  assign empty_o = (cnt_q == '0);

  // Head goes out as soon as it lands
  assign result_req_o = !empty_o;
  assign result_o     = mem_q[rd_ptr_q];
  assign pop          = result_req_o && result_gnt_i;

  ////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push_i && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

//--- masku_top.sv
// Vector mask unit, single 64-bit datapath
// Runs mask-logical writeback and vcpop for the sequencer,
// consuming operand beats and writing merged words or a scalar count

module masku_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Sequencer
  input  masku_pkg::pe_req_t  pe_req_i,
  input  logic                pe_req_valid_i,
  output logic                pe_req_ready_o,
  output logic                done_valid_o,
  output masku_pkg::vid_t     done_id_o,
  // Operand stream
  input  masku_pkg::operand_t operand_i,
  input  logic                operand_valid_i,
  output logic                operand_ready_o,
  // Register file writes
  output masku_pkg::result_t  result_o,
  output logic                result_req_o,
  input  logic                result_gnt_i,
  // Scalar result
  output masku_pkg::elen_t    scalar_o,
  output logic                scalar_valid_o
);

  logic                 accept;
  masku_pkg::masku_op_e busy_op;
  logic                 last_beat;
  logic                 zero_len;
  logic                 beat_fire;
  logic                 beats_left;
  masku_pkg::vlen_t     remaining;
  masku_pkg::vaddr_t    beat_idx;
  logic                 q_full;
  logic                 q_empty;
  logic                 q_push;
  masku_pkg::result_t   q_push_data;
  masku_pkg::elen_t     merged;
  masku_pkg::strb_t     be;
  masku_pkg::cnt_t      popcnt;
  logic                 acc_add;
  logic                 acc_last;
  masku_pkg::cnt_t      acc_popcnt;

  // Fields of the accepted request
  logic                 vm_q;
  masku_pkg::vaddr_t    vd_q;
  masku_pkg::vid_t      id_q;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      vm_q <= pe_req_i.vm;
      vd_q <= pe_req_i.vd;
      id_q <= pe_req_i.id;
    end
  end

  assign done_id_o = id_q;

  ////////////////////////////////
  // Operand handshake
  ////////////////////////////////

  // Counter is nonzero exactly while beats are outstanding
  assign beats_left = (remaining != '0);
  // Logic ops stall on a full result queue
  assign operand_ready_o = beats_left &&
                           ((busy_op == masku_pkg::OP_VCPOP) || !q_full);
  assign beat_fire = operand_valid_i && operand_ready_o;

  ////////////////////////////////
  // Result push
  ////////////////////////////////

  assign q_push = beat_fire && (busy_op == masku_pkg::OP_MASK_LOGIC);

  always_comb begin
    q_push_data.addr  = vd_q + beat_idx;
    q_push_data.id    = id_q;
    q_push_data.wdata = merged;
    q_push_data.be    = be;
  end

  // Accumulator inputs, an empty vcpop adds a single zero at accept
  assign acc_add    = ((busy_op == masku_pkg::OP_VCPOP) && beat_fire) ||
                      (accept && zero_len && (pe_req_i.op == masku_pkg::OP_VCPOP));
  assign acc_popcnt = beat_fire ? popcnt : '0;
  assign acc_last   = beat_fire ? last_beat : 1'b1;

  ////////////////////////////////
  // Submodules
  ////////////////////////////////

  masku_ctrl_fsm u_ctrl_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_valid_i (pe_req_valid_i),
    .req_op_i       (pe_req_i.op),
    .last_beat_i    (last_beat),
    .zero_len_i     (zero_len),
    .beat_fire_i    (beat_fire),
    .queue_empty_i  (q_empty),
    .pe_req_ready_o (pe_req_ready_o),
    .accept_o       (accept),
    .busy_op_o      (busy_op),
    .done_valid_o   (done_valid_o)
  );

  masku_elem_counter u_elem_counter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (accept),
    .vl_i        (pe_req_i.vl),
    .beat_fire_i (beat_fire),
    .remaining_o (remaining),
    .beat_idx_o  (beat_idx),
    .last_beat_o (last_beat),
    .zero_len_o  (zero_len)
  );

  masku_alu u_alu (
    .operand_i   (operand_i),
    .remaining_i (remaining),
    .vm_i        (vm_q),
    .merged_o    (merged),
    .be_o        (be),
    .popcnt_o    (popcnt)
  );

  masku_popcnt_acc u_popcnt_acc (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (accept),
    .add_i          (acc_add),
    .popcnt_i       (acc_popcnt),
    .last_i         (acc_last),
    .scalar_o       (scalar_o),
    .scalar_valid_o (scalar_valid_o)
  );

  masku_result_queue u_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (q_push),
    .push_data_i  (q_push_data),
    .result_gnt_i (result_gnt_i),
    .full_o       (q_full),
    .empty_o      (q_empty),
    .result_o     (result_o),
    .result_req_o (result_req_o)
  );

endmodule

//--- tb_masku.sv
// Testbench for the vector mask unit
// Sends mask-logical and vcpop instructions with random operand beats,
// withholds register file grants at random and checks writes, scalar
// results and handshakes against a reference model

`include "masku_macros.svh"

module tb_masku;

  localparam int Timeout = 200;

  logic                 clk_i;
  logic                 rst_ni;
  masku_pkg::pe_req_t   pe_req;
  logic                 pe_req_valid;
  logic                 pe_req_ready;
  logic                 done_valid;
  masku_pkg::vid_t      done_id;
  masku_pkg::operand_t  operand;
  logic                 operand_valid;
  logic                 operand_ready;
  masku_pkg::result_t   result;
  logic                 result_req;
  logic                 result_gnt;
  masku_pkg::elen_t     scalar;
  logic                 scalar_valid;

  // Expected state of the running instruction
  masku_pkg::result_t   exp_words[$];
  masku_pkg::result_t   exp_head;
  masku_pkg::masku_op_e cur_op;
  masku_pkg::vid_t      cur_id;
  masku_pkg::elen_t     exp_scalar;
  logic                 busy;
  logic                 gnt_stall;
  int                   gnt_left;

  masku_top u_masku_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pe_req_i        (pe_req),
    .pe_req_valid_i  (pe_req_valid),
    .pe_req_ready_o  (pe_req_ready),
    .done_valid_o    (done_valid),
    .done_id_o       (done_id),
    .operand_i       (operand),
    .operand_valid_i (operand_valid),
    .operand_ready_o (operand_ready),
    .result_o        (result),
    .result_req_o    (result_req),
    .result_gnt_i    (result_gnt),
    .scalar_o        (scalar),
    .scalar_valid_o  (scalar_valid)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Element e of the instruction sits at bit e mod 64 of beat e / 64
  function automatic masku_pkg::result_t expect_word(input masku_pkg::operand_t op,
      input int beat, input int vl, input logic vm, input masku_pkg::vaddr_t vd,
      input masku_pkg::vid_t id);
    masku_pkg::result_t r;
    int                 elem;
    r.addr  = vd + masku_pkg::vaddr_t'(beat);
    r.id    = id;
    r.wdata = op.b;
    r.be    = '0;
    for (int i = 0; i < `MASKU_DATA_W; i++) begin
      elem = beat * `MASKU_DATA_W + i;
      if (elem < vl) begin
        // Byte written for any live element including a masked one
        r.be[i / 8] = 1'b1;
        if (vm || op.m[i]) begin
          r.wdata[i] = op.a[i];
        end
      end
    end
    return r;
  endfunction

  function automatic int expect_count(input masku_pkg::operand_t op, input int beat,
      input int vl, input logic vm);
    int n;
    n = 0;
    for (int i = 0; i < `MASKU_DATA_W; i++) begin
      if ((beat * `MASKU_DATA_W + i < vl) && (vm || op.m[i]) && op.b[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  //////////////////////////////
  // Protocol assertions
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy <= 1'b0;
    end else if (pe_req_valid && pe_req_ready) begin
      busy <= 1'b1;
    end else if (done_valid) begin
      busy <= 1'b0;
    end
  end

  assert property (@(posedge clk_i) !rst_ni |-> !pe_req_ready && !operand_ready &&
                   !result_req && !scalar_valid && !done_valid)
    else stop_run($sformatf("[FAIL] %0t: control output high in reset", $time));
  // Ready rises one cycle after reset release
  assert property (@(posedge clk_i) $rose(rst_ni) |-> !pe_req_ready ##1 pe_req_ready)
    else stop_run($sformatf("[FAIL] %0t: request ready wrong after reset", $time));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   result_req && !result_gnt |=> result_req && $stable(result))
    else stop_run($sformatf("[FAIL] %0t: result request changed before grant", $time));
  assert property (@(posedge clk_i) disable iff (!rst_ni) busy |-> !pe_req_ready)
    else stop_run($sformatf("[FAIL] %0t: request ready while busy", $time));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   done_valid |=> pe_req_ready && !done_valid)
    else stop_run($sformatf("[FAIL] %0t: done not a pulse or ready missing", $time));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   scalar_valid |-> done_valid ##1 !scalar_valid)
    else stop_run($sformatf("[FAIL] %0t: scalar pulse apart from done", $time));

  //////////////////////////////
  // Output checks
  //////////////////////////////

  // Writes and completion compared at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni && result_req && result_gnt) begin
      assert (exp_words.size() > 0)
        else stop_run($sformatf("[FAIL] %0t: extra write to %h", $time, result.addr));
      exp_head = exp_words.pop_front();
      assert (result == exp_head)
        else stop_run($sformatf("[FAIL] %0t: write %h, expected %h", $time, result,
                                exp_head));
    end
    if (rst_ni && done_valid) begin
      assert (done_id == cur_id)
        else stop_run($sformatf("[FAIL] %0t: done id %0d, expected %0d", $time, done_id,
                                cur_id));
      if (cur_op == masku_pkg::OP_VCPOP) begin
        assert (scalar_valid && scalar == exp_scalar)
          else stop_run($sformatf("[FAIL] %0t: scalar %0d, expected %0d", $time, scalar,
                                  exp_scalar));
      end else begin
        // Every word granted before done
        assert (exp_words.size() == 0)
          else stop_run($sformatf("[FAIL] %0t: done with %0d words pending", $time,
                                  exp_words.size()));
      end
    end
  end

  // Register file grant toggles after random stretches while stalling
  always @(posedge clk_i) begin
    #1;
    if (!gnt_stall) begin
      result_gnt = 1'b1;
    end else if (gnt_left == 0) begin
      result_gnt = ~result_gnt;
      gnt_left   = $urandom % 5;
    end else begin
      gnt_left--;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic run_instr(input masku_pkg::masku_op_e op, input int vl, input logic vm,
      input masku_pkg::vaddr_t vd, input masku_pkg::vid_t id);
    masku_pkg::operand_t beats[$];
    masku_pkg::operand_t beat;
    masku_pkg::pe_req_t  req;
    int                  count;
    int                  waited;
    count = 0;
    for (int i = 0; i < (vl + `MASKU_DATA_W - 1) / `MASKU_DATA_W; i++) begin
      beat.a = {$urandom, $urandom};
      beat.b = {$urandom, $urandom};
      beat.m = {$urandom, $urandom};
      beats.push_back(beat);
      if (op == masku_pkg::OP_MASK_LOGIC) begin
        exp_words.push_back(expect_word(beat, i, vl, vm, vd, id));
      end else begin
        count += expect_count(beat, i, vl, vm);
      end
    end
    cur_op     = op;
    cur_id     = id;
    exp_scalar = masku_pkg::elen_t'(count);
    req.op = op;
    req.vl = masku_pkg::vlen_t'(vl);
    req.vm = vm;
    req.vd = vd;
    req.id = id;
    pe_req       = req;
    pe_req_valid = 1'b1;
    waited       = 0;
    @(negedge clk_i);
    while (!pe_req_ready) begin
      waited++;
      if (waited > Timeout) begin
        stop_run("Timeout: the unit never accepted the instruction");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    pe_req_valid = 1'b0;
    foreach (beats[i]) begin
      // Random gap before each beat
      repeat ($urandom % 3) begin
        @(posedge clk_i);
        #1;
      end
      operand       = beats[i];
      operand_valid = 1'b1;
      waited        = 0;
      @(negedge clk_i);
      while (!operand_ready) begin
        waited++;
        if (waited > Timeout) begin
          stop_run("Timeout: an operand beat was never accepted");
        end
        @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
      operand_valid = 1'b0;
    end
    waited = 0;
    @(negedge clk_i);
    while (!done_valid) begin
      waited++;
      if (waited > Timeout) begin
        stop_run("Timeout: the instruction never signalled done");
      end
      @(negedge clk_i);
    end
    // vcpop completes in the cycle after its last beat
    if (op == masku_pkg::OP_VCPOP) begin
      assert (waited == 0)
        else stop_run($sformatf("[FAIL] %0t: vcpop done %0d cycles late", $time, waited));
    end
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    void'($urandom(32'h5b23_d5e1));
    rst_ni        = 1'b1;
    pe_req        = '0;
    pe_req_valid  = 1'b0;
    operand       = '0;
    operand_valid = 1'b0;
    result_gnt    = 1'b0;
    gnt_stall     = 1'b0;
    gnt_left      = 0;
    cur_op        = masku_pkg::OP_MASK_LOGIC;
    cur_id        = '0;
    exp_scalar    = '0;
    #1 rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    // Grants always given
    run_instr(masku_pkg::OP_MASK_LOGIC, 150, 1'b1, 8'h20, 3'd1);
    run_instr(masku_pkg::OP_MASK_LOGIC, 150, 1'b0, 8'h40, 3'd2);
    run_instr(masku_pkg::OP_VCPOP, 200, 1'b0, 8'h00, 3'd3);
    run_instr(masku_pkg::OP_VCPOP, 0, 1'b0, 8'h00, 3'd4);
    run_instr(masku_pkg::OP_MASK_LOGIC, 0, 1'b1, 8'h10, 3'd0);
    // Grants withheld in random stretches
    gnt_stall = 1'b1;
    run_instr(masku_pkg::OP_MASK_LOGIC, 300, 1'b0, 8'h80, 3'd5);
    run_instr(masku_pkg::OP_MASK_LOGIC, 129, 1'b1, 8'hf0, 3'd6);
    run_instr(masku_pkg::OP_VCPOP, 64, 1'b1, 8'h00, 3'd7);
    // Cycle after the last done, ready back and scalar pulse over
    @(posedge clk_i);
    #1;
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
masku_pkg.sv
masku_ctrl_fsm.sv
masku_elem_counter.sv
masku_alu.sv
masku_popcnt_acc.sv
masku_result_queue.sv
masku_top.sv
tb_masku.sv

//--- run.sh
#!/bin/sh
# Build and run the mask unit testbench with Verilator
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_masku \
  -o tb_masku_sim \
  && ./obj_dir/tb_masku_sim \
  || exit 1
